//--- files.f
verilog/ddr4_pkg.sv
verilog/noc_rx_decode.sv
verilog/sim_ram_banked.sv
verilog/ddr4_regfile.sv
verilog/noc_tx_reply.sv
verilog/ddr4_sim_top.sv
test/tb_ddr4_sim.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_ddr4_sim -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_ddr4_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^Regression passed$"; then
    exit 0
fi
exit 1

//--- test/tb_ddr4_sim.sv
module tb_ddr4_sim
    import ddr4_pkg::*;
();

    localparam logic [7:0] HOME_ID    = 8'h21;
    localparam int         RAM_AW     = 10;
    localparam int         MAX_CYCLES = 2000;   // generous bound on the whole run

    logic        ddr4_clk = 1'b0;
    logic        ddr4_rst_n;
    logic        flit_valid;
    noc_flit_t   flit;
    logic        tx_stall;
    logic        rx_stall;
    logic        tx_valid;
    noc_flit_t   tx_flit;

    int          seed = 15076;
    int          cycle_cnt = 0;
    int          wr_count = 0;
    int          drop_count = 0;
    logic [31:0] scratch_ref;
    logic [31:0] ref_mem [2**RAM_AW];
    logic [31:0] bank_addr [8];
    noc_flit_t   rd_q[$];    // read requests of the next burst
    noc_flit_t   exp_q[$];   // expected responses in read order

    ddr4_sim_top #(
        .HOME_MODID (HOME_ID),
        .RAM_AWIDTH (RAM_AW),
        .NUM_BANKS  (8)
    ) UUT (
        .ddr4_clk_i   (ddr4_clk),
        .ddr4_rst_n_i (ddr4_rst_n),
        .flit_valid_i (flit_valid),
        .flit_i       (flit),
        .tx_stall_i   (tx_stall),
        .rx_stall_o   (rx_stall),
        .tx_valid_o   (tx_valid),
        .tx_flit_o    (tx_flit)
    );

    always #2 ddr4_clk = ~ddr4_clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    always @(posedge ddr4_clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            report_failure($sformatf("timed out after %0d cycles", cycle_cnt));
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // word is the write data or the return address
    function automatic noc_flit_t make_flit(input logic [3:0] mode, input logic [3:0] bsel,
            input logic [7:0] trg, input logic [7:0] src, input logic [31:0] addr,
            input logic [31:0] word);
        return {mode, bsel, trg, src, addr, word};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nval,
            input logic [3:0] bsel);
        logic [31:0] m;
        m = old;
        for (int i = 0; i < 4; i++) begin
            if (bsel[i]) m[i*8 +: 8] = nval[i*8 +: 8];
        end
        return m;
    endfunction

    task automatic send_flit(input noc_flit_t f);
        @(negedge ddr4_clk);
        flit_valid = 1'b1;
        flit       = f;
        @(negedge ddr4_clk);
        flit_valid = 1'b0;
    endtask

    task automatic mem_write(input logic [31:0] addr, input logic [31:0] data,
            input logic [3:0] bsel);
        send_flit(make_flit(mode_write_c, bsel, HOME_ID, 8'h05, addr, data));
        ref_mem[addr[RAM_AW+1:2]] = merge_bytes(ref_mem[addr[RAM_AW+1:2]], data, bsel);
        wr_count++;
    endtask

    task automatic queue_read(input logic [3:0] mode, input logic [31:0] addr,
            input logic [31:0] exp_data, input logic [7:0] src);
        logic [31:0] ret;
        ret = $random(seed);
        rd_q.push_back(make_flit(mode, 4'hF, HOME_ID, src, addr, ret));
        exp_q.push_back(make_flit(mode_read_resp_c, 4'hF, src, HOME_ID, ret, exp_data));
    endtask

    task automatic idle_check(input int n);
        repeat (n) begin
            @(negedge ddr4_clk);
            if (tx_valid) report_failure("response flit seen while no read was pending");
        end
    endtask

    task automatic compare_response(input noc_flit_t e, input int idx);
        if (!tx_valid) begin
            report_failure($sformatf("response %0d missing at its expected cycle", idx));
        end
        check("tx_flit_o.mode", 32'(tx_flit.mode), 32'(e.mode));
        check("tx_flit_o.bsel", 32'(tx_flit.bsel), 32'(e.bsel));
        check("tx_flit_o.trg_modid", 32'(tx_flit.trg_modid), 32'(e.trg_modid));
        check("tx_flit_o.src_modid", 32'(tx_flit.src_modid), 32'(e.src_modid));
        check("tx_flit_o.payload.wr.addr", tx_flit.payload.wr.addr, e.payload.wr.addr);
        check("tx_flit_o.payload.wr.data", tx_flit.payload.wr.data, e.payload.wr.data);
    endtask

    // back-to-back strobes with an optional stall from the first response on
    task automatic run_reads(input int stall_len);
        int n;
        int idx;
        n = rd_q.size();
        for (int cyc = 0; cyc < n + 5 + stall_len; cyc++) begin
            @(negedge ddr4_clk);
            check("rx_stall_o", 32'(rx_stall), 32'(tx_stall));
            if (cyc <= 4 + stall_len) idx = (cyc >= 4) ? 0 : -1;
            else idx = cyc - 4 - stall_len;
            if (idx >= 0 && idx < n) compare_response(exp_q[idx], idx);
            else if (tx_valid) report_failure("response flit seen while no read was pending");
            tx_stall   = (cyc >= 4 && cyc < 4 + stall_len);
            flit_valid = (cyc < n);
            if (cyc < n) flit = rd_q[cyc];
        end
        rd_q.delete();
        exp_q.delete();
    endtask

    task automatic reset_and_idle();
        repeat (10) begin
            @(negedge ddr4_clk);
            check("tx_valid_o", 32'(tx_valid), 32'd0);
        end
        ddr4_rst_n = 1'b1;
        idle_check(5);
        queue_read(mode_cfg_read_c, 32'h4, 32'd0, 8'h11);
        queue_read(mode_cfg_read_c, 32'h8, 32'd0, 8'h12);
        run_reads(0);
    endtask

    task automatic byte_enable_writes();
        logic [31:0] addr;
        for (int i = 0; i < 4; i++) begin
            addr = 32'h100 + i * 4;
            mem_write(addr, $random(seed), 4'hF);
            mem_write(addr, $random(seed), 4'(3 * i + 1));   // partial merge
        end
        for (int i = 0; i < 4; i++) begin
            addr = 32'h100 + i * 4;
            queue_read(mode_read_req_c, addr, ref_mem[addr[RAM_AW+1:2]], 8'(8'h30 + i));
        end
        run_reads(0);
    endtask

    task automatic bank_interleave();
        for (int b = 0; b < 8; b++) begin
            bank_addr[b] = {20'd0, 3'(b), 7'($random(seed)), 2'b00};
            mem_write(bank_addr[b], $random(seed), 4'hF);
        end
        for (int b = 0; b < 8; b++) begin
            queue_read(mode_read_req_c, bank_addr[b], ref_mem[bank_addr[b][RAM_AW+1:2]], 8'h50);
        end
        run_reads(0);
        // bits above the ram size wrap
        queue_read(mode_read_req_c, bank_addr[5] | 32'h0004_1000,
                   ref_mem[bank_addr[5][RAM_AW+1:2]], 8'h51);
        run_reads(0);
    endtask

    task automatic config_registers();
        scratch_ref = $random(seed);
        send_flit(make_flit(mode_cfg_write_c, 4'hF, HOME_ID, 8'h05, 32'h0, scratch_ref));
        send_flit(make_flit(mode_cfg_write_c, 4'b0101, HOME_ID, 8'h05, 32'h0, 32'hAABBCCDD));
        scratch_ref = merge_bytes(scratch_ref, 32'hAABBCCDD, 4'b0101);
        send_flit(make_flit(mode_cfg_write_c, 4'hF, HOME_ID, 8'h05, 32'h4, 32'hFFFF_FFFF));
        queue_read(mode_cfg_read_c, 32'h0, scratch_ref, 8'h60);
        queue_read(mode_cfg_read_c, 32'h4, 32'(wr_count), 8'h61);
        queue_read(mode_cfg_read_c, 32'hC, 32'd0, 8'h62);   // reg 3 reads zero
        run_reads(0);
    endtask

    task automatic target_filtering();
        send_flit(make_flit(mode_write_c, 4'hF, 8'h22, 8'h05, bank_addr[2], 32'hDEAD_BEEF));
        send_flit(make_flit(mode_cfg_write_c, 4'hF, 8'h00, 8'h05, 32'h0, 32'h0));
        send_flit(make_flit(4'd7, 4'hF, HOME_ID, 8'h05, bank_addr[2], 32'hDEAD_BEEF));
        send_flit(make_flit(mode_read_req_c, 4'hF, 8'h12, 8'h05, bank_addr[2], 32'h0));
        drop_count += 4;
        idle_check(5);
        queue_read(mode_read_req_c, bank_addr[2], ref_mem[bank_addr[2][RAM_AW+1:2]], 8'h70);
        queue_read(mode_cfg_read_c, 32'h8, 32'(drop_count), 8'h71);
        queue_read(mode_cfg_read_c, 32'h4, 32'(wr_count), 8'h72);
        queue_read(mode_cfg_read_c, 32'h0, scratch_ref, 8'h73);   // dropped cfg write
        run_reads(0);
    endtask

    task automatic stall_hold();
        for (int i = 0; i < 3; i++) begin
            queue_read(mode_read_req_c, bank_addr[i + 4], ref_mem[bank_addr[i + 4][RAM_AW+1:2]],
                       8'(8'h80 + i));
        end
        run_reads(4);
    endtask

    initial begin
        ddr4_rst_n = 1'b0;
        flit_valid = 1'b0;
        flit       = '0;
        tx_stall   = 1'b0;
        reset_and_idle();
        byte_enable_writes();
        bank_interleave();
        config_registers();
        target_filtering();
        stall_hold();
        $display("Regression passed");
        $finish;
    end

endmodule

//--- verilog/ddr4_pkg.sv
package ddr4_pkg;

    // flit mode field
    localparam logic [3:0] mode_write_c     = 4'd0;
    localparam logic [3:0] mode_read_req_c  = 4'd1;
    localparam logic [3:0] mode_read_resp_c = 4'd2;
    localparam logic [3:0] mode_cfg_write_c = 4'd3;
    localparam logic [3:0] mode_cfg_read_c  = 4'd4;

    // writes and all responses
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } noc_wr_payload_t;

    // read requests carry the return address in the data slot
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] ret_addr;
    } noc_rd_payload_t;

    typedef union packed {
        noc_wr_payload_t wr;
        noc_rd_payload_t rd;
    } noc_payload_u;

    typedef struct packed {
        logic [3:0]   mode;
        logic [3:0]   bsel;
        logic [7:0]   trg_modid;
        logic [7:0]   src_modid;
        noc_payload_u payload;
    } noc_flit_t;

    typedef enum logic [1:0] {
        ram_write,
        ram_read,
        cfg_write,
        cfg_read
    } req_kind_e;

    typedef struct packed {
        logic        valid;
        req_kind_e   kind;
        logic [3:0]  bsel;
        logic [31:0] word_addr;
        logic [31:0] wdata;
        logic [31:0] ret_addr;
        logic [7:0]  reply_modid;   // src_modid of the request
    } mem_req_t;

endpackage

//--- verilog/ddr4_regfile.sv
module ddr4_regfile
    import ddr4_pkg::*;
(
    input  logic        ddr4_clk_i,
    input  logic        ddr4_rst_n_i,
    input  logic        stall_i,
    input  mem_req_t    req_i,
    input  logic        drop_i,
    output logic [31:0] rdata_o
);

    logic [31:0] r_scratch;
    logic [31:0] r_wr_cnt;
    logic [31:0] r_drop_cnt;
    logic [1:0]  reg_sel;   // addr bits 3:2
    logic        cfg_wr;

    assign reg_sel = req_i.word_addr[1:0];
    assign cfg_wr  = req_i.valid && req_i.kind == cfg_write && reg_sel == 2'd0;

    always_ff @(posedge ddr4_clk_i or negedge ddr4_rst_n_i) begin
        if (!ddr4_rst_n_i) begin
            r_scratch  <= '0;
            r_wr_cnt   <= '0;
            r_drop_cnt <= '0;
        end else if (!stall_i) begin
            for (int i = 0; i < 4; i++) begin
                if (cfg_wr && req_i.bsel[i]) r_scratch[i*8 +: 8] <= req_i.wdata[i*8 +: 8];
            end
            if (req_i.valid && req_i.kind == ram_write) r_wr_cnt <= r_wr_cnt + 32'd1;
            if (drop_i) r_drop_cnt <= r_drop_cnt + 32'd1;
        end
    end

    always_ff @(posedge ddr4_clk_i) begin
        if (!stall_i && req_i.valid && req_i.kind == cfg_read) begin
            case (reg_sel)
                2'd0:    rdata_o <= r_scratch;
                2'd1:    rdata_o <= r_wr_cnt;
                2'd2:    rdata_o <= r_drop_cnt;
                default: rdata_o <= '0;
            endcase
        end
    end

endmodule

//--- verilog/ddr4_sim_top.sv
module ddr4_sim_top
    import ddr4_pkg::*;
#(
    parameter logic [7:0] HOME_MODID = 8'h21,
    parameter int         RAM_AWIDTH = 10,
    parameter int         NUM_BANKS  = 8
) (
    input  logic      ddr4_clk_i,
    input  logic      ddr4_rst_n_i,
    input  logic      flit_valid_i,
    input  noc_flit_t flit_i,
    input  logic      tx_stall_i,
    output logic      rx_stall_o,
    output logic      tx_valid_o,
    output noc_flit_t tx_flit_o
);

    mem_req_t    req;
    logic        drop;
    logic [31:0] ram_rdata;
    logic [31:0] cfg_rdata;

    // no input buffer, so back-pressure goes straight through
    assign rx_stall_o = tx_stall_i;

    noc_rx_decode #(
        .HOME_MODID (HOME_MODID)
    ) i_noc_rx_decode (
        .ddr4_clk_i   (ddr4_clk_i),
        .ddr4_rst_n_i (ddr4_rst_n_i),
        .stall_i      (tx_stall_i),
        .flit_valid_i (flit_valid_i),
        .flit_i       (flit_i),
        .req_o        (req),
        .drop_o       (drop)
    );

    sim_ram_banked #(
        .RAM_AWIDTH (RAM_AWIDTH),
        .NUM_BANKS  (NUM_BANKS)
    ) i_sim_ram_banked (
        .ddr4_clk_i   (ddr4_clk_i),
        .ddr4_rst_n_i (ddr4_rst_n_i),
        .stall_i      (tx_stall_i),
        .req_i        (req),
        .rdata_o      (ram_rdata)
    );

    ddr4_regfile i_ddr4_regfile (
        .ddr4_clk_i   (ddr4_clk_i),
        .ddr4_rst_n_i (ddr4_rst_n_i),
        .stall_i      (tx_stall_i),
        .req_i        (req),
        .drop_i       (drop),
        .rdata_o      (cfg_rdata)
    );

    noc_tx_reply #(
        .HOME_MODID (HOME_MODID)
    ) i_noc_tx_reply (
        .ddr4_clk_i   (ddr4_clk_i),
        .ddr4_rst_n_i (ddr4_rst_n_i),
        .stall_i      (tx_stall_i),
        .req_i        (req),
        .ram_rdata_i  (ram_rdata),
        .cfg_rdata_i  (cfg_rdata),
        .tx_valid_o   (tx_valid_o),
        .tx_flit_o    (tx_flit_o)
    );

endmodule

//--- verilog/noc_rx_decode.sv
module noc_rx_decode
    import ddr4_pkg::*;
#(
    parameter logic [7:0] HOME_MODID = 8'h21
) (
    input  logic      ddr4_clk_i,
    input  logic      ddr4_rst_n_i,
    input  logic      stall_i,
    input  logic      flit_valid_i,
    input  noc_flit_t flit_i,
    output mem_req_t  req_o,
    output logic      drop_o
);

    logic      r_flit_valid;
    noc_flit_t r_flit;
    mem_req_t  req_d;
    logic      mode_known;

    always_ff @(posedge ddr4_clk_i or negedge ddr4_rst_n_i) begin
        if (!ddr4_rst_n_i) begin
            r_flit_valid <= 1'b0;
        end else if (!stall_i) begin
            r_flit_valid <= flit_valid_i;
        end
    end

    always_ff @(posedge ddr4_clk_i) begin
        if (!stall_i && flit_valid_i) r_flit <= flit_i;
    end

    always_comb begin
        req_d             = '0;
        mode_known        = 1'b1;
        req_d.bsel        = r_flit.bsel;
        req_d.reply_modid = r_flit.src_modid;
        case (r_flit.mode)
            mode_write_c, mode_cfg_write_c: begin
                req_d.kind      = (r_flit.mode == mode_write_c) ? ram_write : cfg_write;
                req_d.word_addr = {2'b00, r_flit.payload.wr.addr[31:2]};
                req_d.wdata     = r_flit.payload.wr.data;
            end
            mode_read_req_c, mode_cfg_read_c: begin
                req_d.kind      = (r_flit.mode == mode_read_req_c) ? ram_read : cfg_read;
                req_d.word_addr = {2'b00, r_flit.payload.rd.addr[31:2]};
                req_d.ret_addr  = r_flit.payload.rd.ret_addr;
            end
            default: mode_known = 1'b0;   // incl. stray responses
        endcase
        req_d.valid = r_flit_valid && mode_known && (r_flit.trg_modid == HOME_MODID);
    end

    // counted in the regfile on the next edge
    assign drop_o = r_flit_valid && !req_d.valid;

    always_ff @(posedge ddr4_clk_i or negedge ddr4_rst_n_i) begin
        if (!ddr4_rst_n_i) begin
            req_o <= '0;
        end else if (!stall_i) begin
            req_o <= req_d;
        end
    end

endmodule

//--- verilog/noc_tx_reply.sv
module noc_tx_reply
    import ddr4_pkg::*;
#(
    parameter logic [7:0] HOME_MODID = 8'h21
) (
    input  logic        ddr4_clk_i,
    input  logic        ddr4_rst_n_i,
    input  logic        stall_i,
    input  mem_req_t    req_i,
    input  logic [31:0] ram_rdata_i,
    input  logic [31:0] cfg_rdata_i,
    output logic        tx_valid_o,
    output noc_flit_t   tx_flit_o
);

    logic        is_read;
    logic        r_valid;
    req_kind_e   r_kind;
    logic [31:0] r_ret_addr;
    logic [7:0]  r_reply_modid;
    noc_flit_t   resp_d;

    assign is_read = req_i.valid && (req_i.kind == ram_read || req_i.kind == cfg_read);

    always_ff @(posedge ddr4_clk_i or negedge ddr4_rst_n_i) begin
        if (!ddr4_rst_n_i) begin
            r_valid    <= 1'b0;
            tx_valid_o <= 1'b0;
        end else if (!stall_i) begin
            r_valid    <= is_read;
            tx_valid_o <= r_valid;
        end
    end

    // request side delayed to meet the read data
    always_ff @(posedge ddr4_clk_i) begin
        if (!stall_i) begin
            r_kind        <= req_i.kind;
            r_ret_addr    <= req_i.ret_addr;
            r_reply_modid <= req_i.reply_modid;
        end
    end

    always_comb begin
        resp_d.mode            = mode_read_resp_c;
        resp_d.bsel            = 4'hF;
        resp_d.trg_modid       = r_reply_modid;
        resp_d.src_modid       = HOME_MODID;
        resp_d.payload.wr.addr = r_ret_addr;
        resp_d.payload.wr.data = (r_kind == cfg_read) ? cfg_rdata_i : ram_rdata_i;
    end

    always_ff @(posedge ddr4_clk_i) begin
        if (!stall_i && r_valid) tx_flit_o <= resp_d;   // held until next response
    end

endmodule

//--- verilog/sim_ram_banked.sv
module sim_ram_banked
    import ddr4_pkg::*;
#(
    parameter int RAM_AWIDTH = 10,
    parameter int NUM_BANKS  = 8
) (
    input  logic        ddr4_clk_i,
    input  logic        ddr4_rst_n_i,
    input  logic        stall_i,
    input  mem_req_t    req_i,
    output logic [31:0] rdata_o
);

    localparam int BANK_BITS = $clog2(NUM_BANKS);
    localparam int ROW_BITS  = RAM_AWIDTH - BANK_BITS;

    logic                 ram_access;
    logic                 ram_wr;
    logic [BANK_BITS-1:0] bank_sel;
    logic [BANK_BITS-1:0] r_bank_sel;
    logic [ROW_BITS-1:0]  row;
    logic [NUM_BANKS-1:0] bank_en;
    logic [31:0]          bank_rdata [NUM_BANKS];

    assign ram_wr     = req_i.kind == ram_write;
    assign ram_access = req_i.valid && !stall_i && (ram_wr || req_i.kind == ram_read);

    // upper word address bits pick the bank, higher addresses wrap
    assign bank_sel = req_i.word_addr[RAM_AWIDTH-1 -: BANK_BITS];
    assign row      = req_i.word_addr[ROW_BITS-1:0];
    assign bank_en  = {{(NUM_BANKS-1){1'b0}}, ram_access} << bank_sel;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        logic [31:0] mem [2**ROW_BITS];
        logic [31:0] rdata_q;

        always_ff @(posedge ddr4_clk_i) begin
            if (bank_en[b]) begin
                if (ram_wr) begin
                    for (int i = 0; i < 4; i++) begin
                        if (req_i.bsel[i]) mem[row][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
                    end
                end else begin
                    rdata_q <= mem[row];
                end
            end
        end

        assign bank_rdata[b] = rdata_q;
    end

    // follows the one-cycle ram latency
    always_ff @(posedge ddr4_clk_i or negedge ddr4_rst_n_i) begin
        if (!ddr4_rst_n_i) begin
            r_bank_sel <= '0;
        end else if (!stall_i) begin
            r_bank_sel <= bank_sel;
        end
    end

    assign rdata_o = bank_rdata[r_bank_sel];

endmodule
